// ==== lane_if.sv ====
// Per-lane bundle; lane operands are full width, with FP16 values in the low half
`include "slice_defines.svh"

interface lane_if;
  import slice_pkg::*;

  // Operand side, driven by the splitter
  logic [`SLICE_WIDTH-1:0] a;
  logic [`SLICE_WIDTH-1:0] b;
  fp_format_e              fmt;
  operation_e              op;
  roundmode_e              rnd_mode;
  logic                    mask;

  // Registered results of the lane
  logic [`SLICE_WIDTH-1:0] result;
  status_t                 status;
  logic                    out_mask;

  modport feeder (output a, b, fmt, op, rnd_mode, mask);
  modport lane   (input a, b, fmt, op, rnd_mode, mask, output result, status, out_mask);
  modport packer (input result, status, out_mask);

endinterface

// ==== noncomp_lane.sv ====
// One lane of sign injection and min/max; FP16 uses the low half and leaves the upper half boxed
`include "slice_defines.svh"

module noncomp_lane (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic [`SLICE_PIPE_REGS-1:0] reg_enable_i,
  lane_if.lane                        lane_io
);
  import slice_pkg::*;

  localparam int unsigned W    = `SLICE_WIDTH;
  localparam int unsigned H    = `SLICE_WIDTH / 2;
  localparam int unsigned PIPE = `SLICE_PIPE_REGS;

  logic         sign_a, nan_a, snan_a;
  logic         sign_b, nan_b, snan_b;
  logic [W-2:0] mag_a, mag_b;
  logic         a_lt_b;
  logic         sign_res;
  logic         minmax_nv;
  logic [W-1:0] canon_nan;
  logic [W-1:0] sgnj_res, minmax_res;
  logic [W-1:0] res_d;
  status_t      status_d;

  logic [PIPE-1:0][W-1:0] res_q;
  status_t [PIPE-1:0]     status_q;
  logic [PIPE-1:0]        mask_q;
  logic [PIPE:0][W-1:0]   res_chain;
  status_t [PIPE:0]       status_chain;
  logic [PIPE:0]          mask_chain;

  // Returns sign, NaN and signaling NaN of one operand
  function automatic logic [2:0] classify(input logic [W-1:0] v, input fp_format_e f);
    logic is_nan;
    if (f == FP32) begin
      is_nan = (v[30:23] == 8'hFF) && (v[22:0] != '0);
      return {v[31], is_nan, is_nan & ~v[22]};
    end
    is_nan = (v[14:10] == 5'h1F) && (v[9:0] != '0);
    return {v[15], is_nan, is_nan & ~v[9]};
  endfunction

  // --------------------------------------------------
  // Operand decode
  // --------------------------------------------------
  assign {sign_a, nan_a, snan_a} = classify(lane_io.a, lane_io.fmt);
  assign {sign_b, nan_b, snan_b} = classify(lane_io.b, lane_io.fmt);

  assign mag_a = (lane_io.fmt == FP32) ? lane_io.a[W-2:0] : {{(W-H){1'b0}}, lane_io.a[H-2:0]};
  assign mag_b = (lane_io.fmt == FP32) ? lane_io.b[W-2:0] : {{(W-H){1'b0}}, lane_io.b[H-2:0]};

  assign canon_nan = (lane_io.fmt == FP32) ? CANON_NAN_FP32 : {{H{1'b1}}, CANON_NAN_FP16};

  // Sign-magnitude order, so -0 sorts below +0
  assign a_lt_b = (sign_a != sign_b) ? sign_a
                : (sign_a ? (mag_a > mag_b) : (mag_a < mag_b));

  always_comb begin
    // Sign injection variants
    case (lane_io.rnd_mode)
      RNE:     sign_res = sign_b;
      RTZ:     sign_res = ~sign_b;
      RDN:     sign_res = sign_a ^ sign_b;
      default: sign_res = sign_a;
    endcase
    sgnj_res = lane_io.a;
    if (lane_io.fmt == FP32) begin
      sgnj_res[W-1] = sign_res;
    end else begin
      sgnj_res[H-1] = sign_res;
    end

    // Min/max, RNE is min and RTZ is max
    minmax_res = lane_io.a;
    minmax_nv  = 1'b0;
    if (lane_io.rnd_mode == RNE || lane_io.rnd_mode == RTZ) begin
      minmax_nv = snan_a | snan_b;
      if (nan_a && nan_b) begin
        minmax_res = canon_nan;
      end else if (nan_a) begin
        minmax_res = lane_io.b;
      end else if (nan_b) begin
        minmax_res = lane_io.a;
      end else if (lane_io.rnd_mode == RNE) begin
        minmax_res = a_lt_b ? lane_io.a : lane_io.b;
      end else begin
        minmax_res = a_lt_b ? lane_io.b : lane_io.a;
      end
    end

    status_d    = '0;
    res_d       = sgnj_res;
    if (lane_io.op == MINMAX) begin
      res_d       = minmax_res;
      status_d.nv = minmax_nv;
    end
    // Box the FP16 result in its own lane word
    if (lane_io.fmt == FP16) begin
      res_d[W-1:H] = '1;
    end
  end

  // --------------------------------------------------
  // Result pipeline, enabled by the control chain
  // --------------------------------------------------
  assign res_chain    = {res_q, res_d};
  assign status_chain = {status_q, status_d};
  assign mask_chain   = {mask_q, lane_io.mask};

  always_ff @(posedge clk_i) begin
    for (int i = 0; i < PIPE; i++) begin
      if (reg_enable_i[i]) begin
        res_q[i]    <= res_chain[i];
        status_q[i] <= status_chain[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      mask_q <= '0;
    end else begin
      for (int i = 0; i < PIPE; i++) begin
        if (reg_enable_i[i]) begin
          mask_q[i] <= mask_chain[i];
        end
      end
    end
  end

  assign lane_io.result   = res_chain[PIPE];
  assign lane_io.status   = status_chain[PIPE];
  assign lane_io.out_mask = mask_chain[PIPE];

endmodule

// ==== noncomp_slice.sv ====
// Two-lane non-computational FP slice; latency SLICE_PIPE_REGS cycles, flush drops all items in flight
`include "slice_defines.svh"

module noncomp_slice (
  input  logic                         clk_i,
  input  logic                         reset_i,
  input  logic [1:0][`SLICE_WIDTH-1:0] operands_i,
  input  slice_pkg::operation_e        op_i,
  input  slice_pkg::roundmode_e        rnd_mode_i,
  input  slice_pkg::fp_format_e        fmt_i,
  input  logic                         vectorial_op_i,
  input  logic [`SLICE_TAG_BITS-1:0]   tag_i,
  input  logic [`SLICE_LANES-1:0]      simd_mask_i,
  input  logic                         in_valid_i,
  output logic                         in_ready_o,
  input  logic                         flush_i,
  output logic [`SLICE_WIDTH-1:0]      result_o,
  output slice_pkg::status_t           status_o,
  output logic [`SLICE_TAG_BITS-1:0]   tag_o,
  output logic                         out_valid_o,
  input  logic                         out_ready_i,
  output logic                         busy_o
);
  import slice_pkg::*;

  logic [`SLICE_LANES-1:0]     in_lane_active;
  logic [`SLICE_LANES-1:0]     out_lane_active;
  fp_format_e                  out_fmt;
  logic [`SLICE_PIPE_REGS-1:0] reg_enable;

  lane_if lanes [`SLICE_LANES] ();

  slice_ctrl u_ctrl (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .in_valid_i    (in_valid_i),
    .in_ready_o    (in_ready_o),
    .flush_i       (flush_i),
    .tag_i         (tag_i),
    .fmt_i         (fmt_i),
    .lane_active_i (in_lane_active),
    .out_valid_o   (out_valid_o),
    .out_ready_i   (out_ready_i),
    .tag_o         (tag_o),
    .fmt_o         (out_fmt),
    .lane_active_o (out_lane_active),
    .busy_o        (busy_o),
    .reg_enable_o  (reg_enable)
  );

  operand_splitter u_splitter (
    .operands_i     (operands_i),
    .op_i           (op_i),
    .rnd_mode_i     (rnd_mode_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .simd_mask_i    (simd_mask_i),
    .lane_active_o  (in_lane_active),
    .lanes_o        (lanes)
  );

  for (genvar l = 0; l < `SLICE_LANES; l++) begin : gen_lanes
    noncomp_lane u_lane (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .reg_enable_i (reg_enable),
      .lane_io      (lanes[l])
    );
  end

  result_packer u_packer (
    .fmt_i         (out_fmt),
    .lane_active_i (out_lane_active),
    .lanes_i       (lanes),
    .result_o      (result_o),
    .status_o      (status_o)
  );

endmodule

// ==== operand_splitter.sv ====
// Lane 1 only carries FP16 vector work; the vector flag has no effect for FP32
`include "slice_defines.svh"

module operand_splitter (
  input  logic [1:0][`SLICE_WIDTH-1:0] operands_i,
  input  slice_pkg::operation_e        op_i,
  input  slice_pkg::roundmode_e        rnd_mode_i,
  input  slice_pkg::fp_format_e        fmt_i,
  input  logic                         vectorial_op_i,
  input  logic [`SLICE_LANES-1:0]      simd_mask_i,
  output logic [`SLICE_LANES-1:0]      lane_active_o,
  lane_if.feeder                       lanes_o [`SLICE_LANES]
);
  import slice_pkg::*;

  localparam int unsigned LANES = `SLICE_LANES;
  localparam int unsigned H     = `SLICE_WIDTH / 2;

  fp_word_u op_a;
  fp_word_u op_b;

  assign op_a = operands_i[0];
  assign op_b = operands_i[1];

  for (genvar l = 0; l < LANES; l++) begin : gen_feed
    if (l == 0) begin : gen_lane0
      // Full word for FP32, low half otherwise
      assign lanes_o[l].a = (fmt_i == FP32) ? op_a.fp32 : {{H{1'b0}}, op_a.fp16[0]};
      assign lanes_o[l].b = (fmt_i == FP32) ? op_b.fp32 : {{H{1'b0}}, op_b.fp16[0]};
    end else begin : gen_upper
      assign lanes_o[l].a = {{H{1'b0}}, op_a.fp16[l]};
      assign lanes_o[l].b = {{H{1'b0}}, op_b.fp16[l]};
    end

    assign lane_active_o[l] = (l == 0) || ((fmt_i == FP16) && vectorial_op_i);

    assign lanes_o[l].fmt      = fmt_i;
    assign lanes_o[l].op       = op_i;
    assign lanes_o[l].rnd_mode = rnd_mode_i;
    assign lanes_o[l].mask     = simd_mask_i[l];
  end

endmodule

// ==== result_packer.sv ====
// Output assembly for two lanes; inactive FP16 upper halves read as all ones (NaN-boxed)
`include "slice_defines.svh"

module result_packer (
  input  slice_pkg::fp_format_e   fmt_i,
  input  logic [`SLICE_LANES-1:0] lane_active_i,
  lane_if.packer                  lanes_i [`SLICE_LANES],
  output logic [`SLICE_WIDTH-1:0] result_o,
  output slice_pkg::status_t      status_o
);
  import slice_pkg::*;

  localparam int unsigned W     = `SLICE_WIDTH;
  localparam int unsigned H     = `SLICE_WIDTH / 2;
  localparam int unsigned LANES = `SLICE_LANES;

  logic [LANES-1:0][W-1:0] lane_res;
  status_t [LANES-1:0]     lane_status;
  logic [LANES-1:0]        lane_mask;
  fp_word_u                packed_word;
  status_t                 status_acc;

  for (genvar l = 0; l < LANES; l++) begin : gen_collect
    assign lane_res[l]    = lanes_i[l].result;
    assign lane_status[l] = lanes_i[l].status;
    assign lane_mask[l]   = lanes_i[l].out_mask;
  end

  // Lane 0 always fills the low half; FP16 replaces the upper half
  always_comb begin
    packed_word.fp32 = lane_res[0];
    if (fmt_i == FP16) begin
      packed_word.fp16[1] = lane_active_i[1] ? lane_res[1][H-1:0] : {H{1'b1}};
    end
  end

  // Only active lanes with their mask bit set report flags
  always_comb begin
    status_acc = '0;
    for (int l = 0; l < LANES; l++) begin
      if (lane_active_i[l] && lane_mask[l]) begin
        status_acc = status_acc | lane_status[l];
      end
    end
  end

  assign result_o = packed_word;
  assign status_o = status_acc;

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module tb_noncomp_slice -f tb.f
./obj_dir/Vtb_noncomp_slice | tee sim.log
if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

// ==== slice_assert.sv ====
// Handshake properties of the slice top level; outputs are assumed to hold only when not flushed
module slice_assert (
  input logic               clk_i,
  input logic               reset_i,
  input logic               flush_i,
  input logic               in_ready_o,
  input logic               out_valid_o,
  input logic               out_ready_i,
  input logic               busy_o,
  input logic [31:0]        result_o,
  input slice_pkg::status_t status_o,
  input logic [3:0]         tag_o
);
  timeunit 1ns;
  timeprecision 100ps;

  // A stalled output keeps its item
  output_hold: assert property (@(posedge clk_i) disable iff (reset_i)
    out_valid_o && !out_ready_i && !flush_i |=>
      out_valid_o && $stable(result_o) && $stable(status_o) && $stable(tag_o))
    else $error("output changed while stalled");

  reset_quiet: assert property (@(posedge clk_i) reset_i |=> !out_valid_o)
    else $error("out_valid_o high during reset");

  // An empty pipeline always takes new work
  idle_ready: assert property (@(posedge clk_i) disable iff (reset_i) !busy_o |-> in_ready_o)
    else $error("in_ready_o low while idle");

endmodule

bind noncomp_slice slice_assert u_assert (
  .clk_i       (clk_i),
  .reset_i     (reset_i),
  .flush_i     (flush_i),
  .in_ready_o  (in_ready_o),
  .out_valid_o (out_valid_o),
  .out_ready_i (out_ready_i),
  .busy_o      (busy_o),
  .result_o    (result_o),
  .status_o    (status_o),
  .tag_o       (tag_o)
);

// ==== slice_ctrl.sv ====
// Control chain of SLICE_PIPE_REGS stages; an item accepted at an edge reaches the output at edge N
`include "slice_defines.svh"

module slice_ctrl (
  input  logic                        clk_i,
  input  logic                        reset_i,
  input  logic                        in_valid_i,
  output logic                        in_ready_o,
  input  logic                        flush_i,
  input  logic [`SLICE_TAG_BITS-1:0]  tag_i,
  input  slice_pkg::fp_format_e       fmt_i,
  input  logic [`SLICE_LANES-1:0]     lane_active_i,
  output logic                        out_valid_o,
  input  logic                        out_ready_i,
  output logic [`SLICE_TAG_BITS-1:0]  tag_o,
  output slice_pkg::fp_format_e       fmt_o,
  output logic [`SLICE_LANES-1:0]     lane_active_o,
  output logic                        busy_o,
  output logic [`SLICE_PIPE_REGS-1:0] reg_enable_o
);
  import slice_pkg::*;

  localparam int unsigned PIPE  = `SLICE_PIPE_REGS;
  localparam int unsigned TAGW  = `SLICE_TAG_BITS;
  localparam int unsigned LANES = `SLICE_LANES;

  // Stage registers, index i is stage i
  logic [PIPE-1:0]             valid_q;
  logic [PIPE-1:0][TAGW-1:0]   tag_q;
  logic [PIPE-1:0]             fmt_q;
  logic [PIPE-1:0][LANES-1:0]  active_q;

  // Chains: entry 0 is the input side, entry i+1 the output of stage i
  logic [PIPE:0]               valid_chain;
  logic [PIPE:0][TAGW-1:0]     tag_chain;
  logic [PIPE:0]               fmt_chain;
  logic [PIPE:0][LANES-1:0]    active_chain;

  logic [PIPE-1:0]             stage_ready;

  assign valid_chain  = {valid_q, in_valid_i};
  assign tag_chain    = {tag_q, tag_i};
  assign fmt_chain    = {fmt_q, fmt_i};
  assign active_chain = {active_q, lane_active_i};

  // --------------------------------------------------
  // Accept chain
  // --------------------------------------------------
  // Stage i accepts if it or any later stage is empty, or the output drains
  always_comb begin
    for (int i = 0; i < PIPE; i++) begin
      stage_ready[i] = out_ready_i | ~&(valid_q | PIPE'((1 << i) - 1));
    end
  end

  assign reg_enable_o = valid_chain[PIPE-1:0] & stage_ready;

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_q <= '0;
    end else begin
      for (int i = 0; i < PIPE; i++) begin
        if (stage_ready[i]) begin
          valid_q[i] <= valid_chain[i];
        end
      end
    end
  end

  // Side data moves with the lane registers
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < PIPE; i++) begin
      if (reg_enable_o[i]) begin
        tag_q[i]    <= tag_chain[i];
        fmt_q[i]    <= fmt_chain[i];
        active_q[i] <= active_chain[i];
      end
    end
  end

  // --------------------------------------------------
  // Output side
  // --------------------------------------------------
  assign in_ready_o    = stage_ready[0];
  assign out_valid_o   = valid_chain[PIPE];
  assign tag_o         = tag_chain[PIPE];
  assign fmt_o         = fp_format_e'(fmt_chain[PIPE]);
  assign lane_active_o = active_chain[PIPE];
  assign busy_o        = |valid_q;

endmodule

// ==== slice_defines.svh ====
// Build constants; SLICE_PIPE_REGS must be 1 or more and SLICE_LANES is tied to a 32-bit FP16 pair
`ifndef SLICE_DEFINES_SVH
`define SLICE_DEFINES_SVH

// --------------------------------------------------
// Datapath geometry
// --------------------------------------------------
`define SLICE_WIDTH 32
`define SLICE_LANES 2

// User tag carried alongside each item
`define SLICE_TAG_BITS 4

// --------------------------------------------------
// Register stages behind the lane compute logic
// --------------------------------------------------
// Zero stages is not a legal setting
`define SLICE_PIPE_REGS 2

`endif

// ==== slice_pkg.sv ====
// Shared types of the slice; only NV of status_t is ever raised and only RNE/RTZ/RDN select variants
`include "slice_defines.svh"

package slice_pkg;

  typedef enum logic {
    FP32 = 1'b0,
    FP16 = 1'b1
  } fp_format_e;

  typedef enum logic {
    SGNJ   = 1'b0,
    MINMAX = 1'b1
  } operation_e;

  // RISC-V rounding-mode encoding, reused as operation variant select
  typedef enum logic [2:0] {
    RNE = 3'b000,
    RTZ = 3'b001,
    RDN = 3'b010,
    RUP = 3'b011,
    RMM = 3'b100,
    DYN = 3'b111
  } roundmode_e;

  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

  // One datapath word seen as a single FP32 value or as two FP16 values
  typedef union packed {
    logic [`SLICE_WIDTH-1:0]          fp32;
    logic [1:0][`SLICE_WIDTH/2-1:0]   fp16;
  } fp_word_u;

  localparam logic [31:0] CANON_NAN_FP32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN_FP16 = 16'h7E00;

endpackage

// ==== tb.f ====
+incdir+.
slice_pkg.sv
lane_if.sv
slice_ctrl.sv
operand_splitter.sv
noncomp_lane.sv
result_packer.sv
noncomp_slice.sv
slice_assert.sv
tb_noncomp_slice.sv

// ==== tb_noncomp_slice.sv ====
// Self-checking testbench; expects SLICE_PIPE_REGS >= 1 and stops itself at a fixed cycle limit
`include "slice_defines.svh"

module tb_noncomp_slice;
  import slice_pkg::*;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int PIPE        = `SLICE_PIPE_REGS;
  localparam int TEST_ITEMS  = 24 + 32 + 40 + 40 + 300 + 22;
  localparam int CYCLE_LIMIT = 2 * (TEST_ITEMS + 16) + 600;

  typedef struct packed {
    logic [31:0] res;
    logic [4:0]  status;
    logic [3:0]  tag;
    int          cyc;
  } expect_t;

  logic                   clk;
  logic                   reset_i;
  logic [1:0][31:0]       operands_i;
  operation_e             op_i;
  roundmode_e             rnd_mode_i;
  fp_format_e             fmt_i;
  logic                   vectorial_op_i;
  logic [3:0]             tag_i;
  logic [1:0]             simd_mask_i;
  logic                   in_valid_i;
  logic                   in_ready_o;
  logic                   flush_i;
  logic [31:0]            result_o;
  status_t                status_o;
  logic [3:0]             tag_o;
  logic                   out_valid_o;
  logic                   out_ready_i;
  logic                   busy_o;

  expect_t     exp_q[$];
  expect_t     exp_item;
  logic [31:0] lfsr_state = 32'ha491ca83;
  logic [31:0] bp_state   = 32'ha491ca83;
  logic [3:0]  next_tag   = '0;
  logic        bp_random  = 1'b0;
  logic        lat_check  = 1'b1;
  int          cycle      = 0;
  int          errors     = 0;
  int          checked    = 0;
  int          err_mark   = 0;
  int          item_mark  = 0;

  noncomp_slice dut_i (
    .clk_i          (clk),
    .reset_i        (reset_i),
    .operands_i     (operands_i),
    .op_i           (op_i),
    .rnd_mode_i     (rnd_mode_i),
    .fmt_i          (fmt_i),
    .vectorial_op_i (vectorial_op_i),
    .tag_i          (tag_i),
    .simd_mask_i    (simd_mask_i),
    .in_valid_i     (in_valid_i),
    .in_ready_o     (in_ready_o),
    .flush_i        (flush_i),
    .result_o       (result_o),
    .status_o       (status_o),
    .tag_o          (tag_o),
    .out_valid_o    (out_valid_o),
    .out_ready_i    (out_ready_i),
    .busy_o         (busy_o)
  );

  always #5 clk = ~clk;

  // --------------------------------------------------
  // Random source and stimulus shaping
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v          = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_step(lfsr_state);
    end
    return v;
  endfunction

  // Half of the values are NaNs, zeros or copies of the other magnitude
  function automatic logic [31:0] rand_single(input logic [31:0] other);
    logic [2:0]  kind;
    logic [31:0] v;
    kind = 3'(rand_bits(3));
    v    = rand_bits(32);
    case (kind)
      3'd0:    v = {v[31], 8'hFF, 1'b1, v[21:0]};
      3'd1:    v = {v[31], 8'hFF, 1'b0, v[21:1], 1'b1};
      3'd2:    v = {v[31], 31'h0};
      3'd3:    v = {v[31], other[30:0]};
      default: ;
    endcase
    return v;
  endfunction

  function automatic logic [15:0] rand_half(input logic [15:0] other);
    logic [2:0]  kind;
    logic [15:0] v;
    kind = 3'(rand_bits(3));
    v    = 16'(rand_bits(16));
    case (kind)
      3'd0:    v = {v[15], 5'h1F, 1'b1, v[8:0]};
      3'd1:    v = {v[15], 5'h1F, 1'b0, v[8:1], 1'b1};
      3'd2:    v = {v[15], 15'h0};
      3'd3:    v = {v[15], other[14:0]};
      default: ;
    endcase
    return v;
  endfunction

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------
  // Returns {nv, value}; FP16 values sit in the low half
  function automatic logic [32:0] ref_lane(input logic [31:0] a, input logic [31:0] b,
                                           input logic mm, input logic [2:0] rnd,
                                           input logic half);
    logic        sa, sb, na, nb, sna, snb, ns, nv;
    logic [31:0] ka, kb, res;
    if (half) begin
      sa  = a[15];
      sb  = b[15];
      na  = (&a[14:10]) && (|a[9:0]);
      nb  = (&b[14:10]) && (|b[9:0]);
      sna = na && !a[9];
      snb = nb && !b[9];
      ka  = {16'h0, sa ? ~a[15:0] : (a[15:0] | 16'h8000)};
      kb  = {16'h0, sb ? ~b[15:0] : (b[15:0] | 16'h8000)};
    end else begin
      sa  = a[31];
      sb  = b[31];
      na  = (&a[30:23]) && (|a[22:0]);
      nb  = (&b[30:23]) && (|b[22:0]);
      sna = na && !a[22];
      snb = nb && !b[22];
      ka  = sa ? ~a : (a | 32'h8000_0000);
      kb  = sb ? ~b : (b | 32'h8000_0000);
    end
    res = a;
    nv  = 1'b0;
    if (!mm && rnd <= 3'd2) begin
      ns = (rnd == 3'd0) ? sb : (rnd == 3'd1) ? ~sb : (sa ^ sb);
      if (half) res[15] = ns;
      else res[31] = ns;
    end else if (mm && rnd <= 3'd1) begin
      nv = sna | snb;
      if (na && nb) res = half ? 32'h0000_7E00 : 32'h7FC0_0000;
      else if (na) res = b;
      else if (nb) res = a;
      else if ((ka < kb) == (rnd == 3'd0)) res = a;
      else res = b;
    end
    return {nv, res};
  endfunction

  // Returns {status, result} for a whole input word pair
  function automatic logic [36:0] ref_slice(input logic [31:0] a, input logic [31:0] b,
                                            input logic mm, input logic [2:0] rnd,
                                            input logic half, input logic vec,
                                            input logic [1:0] mask);
    logic [32:0] l0, l1;
    logic [31:0] r;
    logic        nv;
    if (!half) begin
      l0 = ref_lane(a, b, mm, rnd, 1'b0);
      r  = l0[31:0];
      nv = l0[32] & mask[0];
    end else begin
      l0 = ref_lane({16'h0, a[15:0]}, {16'h0, b[15:0]}, mm, rnd, 1'b1);
      l1 = ref_lane({16'h0, a[31:16]}, {16'h0, b[31:16]}, mm, rnd, 1'b1);
      r  = {vec ? l1[15:0] : 16'hFFFF, l0[15:0]};
      nv = (l0[32] & mask[0]) | (vec & l1[32] & mask[1]);
    end
    return {nv, 4'b0, r};
  endfunction

  // --------------------------------------------------
  // Checking
  // --------------------------------------------------
  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      errors++;
      $display("error at %0t: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // Transfers are decided at the falling edge, where all inputs and outputs are settled
  always @(negedge clk) begin
    if (!reset_i && flush_i) begin
      exp_q.delete();
    end else if (!reset_i) begin
      if (out_valid_o && out_ready_i) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("unexpected output with no item pending at %0t", $time);
        end else begin
          exp_item = exp_q.pop_front();
          checked++;
          check_val("result_o", result_o, exp_item.res);
          check_val("status_o", status_o, exp_item.status);
          check_val("tag_o", tag_o, exp_item.tag);
          if (lat_check) check_val("latency", cycle - exp_item.cyc, PIPE);
        end
      end
      if (in_valid_i && in_ready_o) begin
        {exp_item.status, exp_item.res} = ref_slice(operands_i[0], operands_i[1], op_i,
                                                    rnd_mode_i, fmt_i, vectorial_op_i,
                                                    simd_mask_i);
        exp_item.tag = tag_i;
        exp_item.cyc = cycle;
        exp_q.push_back(exp_item);
      end
    end
  end

  always @(posedge clk) begin
    cycle++;
    if (cycle > CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  // Output back-pressure with its own random stream
  always @(posedge clk) begin
    #1;
    if (bp_random) begin
      bp_state    = lfsr_step(bp_state);
      out_ready_i = bp_state[0];
    end
  end

  // --------------------------------------------------
  // Drivers
  // --------------------------------------------------
  task automatic send_item(input logic [31:0] a, input logic [31:0] b, input logic mm,
                           input logic [2:0] rnd, input logic half, input logic vec,
                           input logic [1:0] mask);
    operands_i[0]  = a;
    operands_i[1]  = b;
    op_i           = operation_e'(mm);
    rnd_mode_i     = roundmode_e'(rnd);
    fmt_i          = fp_format_e'(half);
    vectorial_op_i = vec;
    simd_mask_i    = mask;
    tag_i          = next_tag;
    in_valid_i     = 1'b1;
    do @(negedge clk); while (!in_ready_o);
    @(posedge clk);
    #1;
    in_valid_i = 1'b0;
    next_tag   = next_tag + 4'd1;
  endtask

  // Mode 0 FP32, 1 FP16 scalar, 2 FP16 vector, 3 mixed; op_sel 2 picks the operation at random
  task automatic random_items(input int n, input int mode, input int op_sel);
    logic [1:0]  pick;
    logic [2:0]  rnd;
    logic [31:0] a, b;
    logic        half, vec, mm;
    for (int i = 0; i < n; i++) begin
      pick = (mode == 3) ? 2'(rand_bits(2)) : 2'(mode);
      half = (pick != 2'd0);
      vec  = (pick >= 2'd2) || (pick == 2'd0 && rand_bits(1) != 0);
      if (!half) begin
        a = rand_single(rand_bits(32));
        b = rand_single(a);
      end else begin
        a = {rand_half(16'(rand_bits(16))), rand_half(16'(rand_bits(16)))};
        b = {rand_half(a[31:16]), rand_half(a[15:0])};
      end
      mm  = (op_sel == 2) ? rand_bits(1) != 0 : (op_sel == 1);
      rnd = 3'(rand_bits(2));
      if (rnd == 3'd3) rnd = 3'(rand_bits(3));
      send_item(a, b, mm, rnd, half, vec, 2'(rand_bits(2)));
    end
  endtask

  task automatic finish_test(input string name);
    do @(negedge clk); while (exp_q.size() != 0 || busy_o);
    @(posedge clk);
    #1;
    $display("test %s: %0d items checked, %0d errors", name, checked - item_mark,
             errors - err_mark);
    item_mark = checked;
    err_mark  = errors;
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    clk            = 1'b0;
    reset_i        = 1'b1;
    operands_i     = '0;
    op_i           = SGNJ;
    rnd_mode_i     = RNE;
    fmt_i          = FP32;
    vectorial_op_i = 1'b0;
    tag_i          = '0;
    simd_mask_i    = '0;
    in_valid_i     = 1'b0;
    flush_i        = 1'b0;
    out_ready_i    = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;

    // Mode 3 is RUP, which leaves a unchanged
    for (int r = 0; r < 4; r++) begin
      send_item(32'h3F80_0000, 32'hBF80_0000, 1'b0, 3'(r), 1'b0, 1'b0, 2'b11);
      send_item(32'hC049_0FDB, 32'h4049_0FDB, 1'b0, 3'(r), 1'b0, 1'b0, 2'b11);
    end
    random_items(16, 0, 0);
    finish_test("fp32 sign injection");

    send_item(32'h0000_0000, 32'h8000_0000, 1'b1, 3'd0, 1'b0, 1'b0, 2'b11);
    send_item(32'h8000_0000, 32'h0000_0000, 1'b1, 3'd1, 1'b0, 1'b0, 2'b11);
    send_item(32'h7FC0_0000, 32'h3F80_0000, 1'b1, 3'd0, 1'b0, 1'b0, 2'b11);
    send_item(32'hBF80_0000, 32'h7FC0_0001, 1'b1, 3'd1, 1'b0, 1'b0, 2'b11);
    send_item(32'h7FC0_0000, 32'hFFC0_0000, 1'b1, 3'd0, 1'b0, 1'b0, 2'b11);
    send_item(32'h7F80_0001, 32'h4000_0000, 1'b1, 3'd0, 1'b0, 1'b0, 2'b11);
    send_item(32'h4000_0000, 32'hFF80_0010, 1'b1, 3'd1, 1'b0, 1'b0, 2'b11);
    send_item(32'h7F80_0001, 32'h7FC0_0000, 1'b1, 3'd1, 1'b0, 1'b0, 2'b11);
    random_items(24, 0, 1);
    finish_test("fp32 min/max");

    random_items(40, 1, 2);
    finish_test("fp16 scalar");

    random_items(40, 2, 2);
    finish_test("fp16 vector");

    lat_check = 1'b0;
    bp_random = 1'b1;
    random_items(300, 3, 2);
    finish_test("random back-pressure");
    bp_random   = 1'b0;
    out_ready_i = 1'b1;

    // Fill every stage, then drop the items in flight
    out_ready_i = 1'b0;
    random_items(PIPE, 3, 2);
    @(negedge clk);
    check_val("in_ready_o", in_ready_o, 1'b0);
    check_val("busy_o", busy_o, 1'b1);
    @(posedge clk);
    #1;
    flush_i = 1'b1;
    @(posedge clk);
    #1;
    flush_i = 1'b0;
    @(negedge clk);
    check_val("busy_o", busy_o, 1'b0);
    @(posedge clk);
    #1;
    out_ready_i = 1'b1;
    lat_check   = 1'b1;
    repeat (2 * PIPE) @(posedge clk);
    #1;
    random_items(20, 3, 2);
    finish_test("flush");

    $display("summary: 6 tests, %0d items checked, %0d errors", checked, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule
